/* pmp_consts.svh */
`ifndef PMP_CONSTS_SVH
`define PMP_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define PA_WIDTH    34

// PMP table geometry
`define PMP_ENTRIES 8
`define PMP_IDX_W   3

// CSR numbering
`define CSR_ADDR_W  12

`define CSR_MISA     12'h301
`define CSR_MSCRATCH 12'h340

// pmpcfgN and pmpaddrN follow these bases
`define CSR_PMPCFG0  12'h3A0
`define CSR_PMPADDR0 12'h3B0

// RV32 with I, M, S and U extensions
`define MISA_VALUE  32'h4014_1100

`endif

/* pmp_pkg.sv */
`default_nettype none
`include "pmp_consts.svh"

package pmp_pkg;

  // Code 3 is left unassigned and decodes as illegal
  typedef enum logic [1:0] {
    CSR_RW = 2'd0,
    CSR_RS = 2'd1,
    CSR_RC = 2'd2
  } csr_op_t;

  // Address matching mode, A field of the config byte
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_t;

  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_t mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  // Byte k of pmpcfgN configures entry 4N+k
  typedef union packed {
    logic [`XLEN-1:0]             raw;
    pmp_cfg_t [`XLEN/8-1:0]       entry;
  } pmpcfg_word_u;

endpackage

`default_nettype wire

/* csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pmp_consts.svh"

module csr_regfile
  import pmp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   csr_req,
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_op_t                csr_op,
  input  logic [`XLEN-1:0]       csr_wdata,
  output logic                   csr_ack,
  output logic [`XLEN-1:0]       csr_rdata,
  output logic                   csr_invalid,
  output pmp_cfg_t               entry_cfg [`PMP_ENTRIES],
  output logic [`XLEN-1:0]       entry_addr [`PMP_ENTRIES]
);

  localparam int CFG_WORDS = `PMP_ENTRIES / 4;
  localparam int CFG_IDX_W = (CFG_WORDS > 1) ? $clog2(CFG_WORDS) : 1;

  logic [`XLEN-1:0]       mscratch;
  pmpcfg_word_u           pmpcfg [CFG_WORDS];
  logic [`XLEN-1:0]       pmpaddr [`PMP_ENTRIES];

  logic [`CSR_ADDR_W-1:0] cfg_off;
  logic [`CSR_ADDR_W-1:0] addr_off;
  logic                   is_misa;
  logic                   is_mscratch;
  logic                   is_cfg;
  logic                   is_addr;
  logic [CFG_IDX_W-1:0]   cfg_sel;
  logic [`PMP_IDX_W-1:0]  addr_sel;
  logic                   op_ok;
  logic                   access_bad;
  logic                   start;
  logic [`XLEN-1:0]       old_val;
  logic [`XLEN-1:0]       new_val;

  // A request is served once, on the first edge it is seen
  assign start = csr_req && !csr_ack;

  // Address decode
  always_comb begin
    cfg_off     = csr_addr - `CSR_PMPCFG0;
    addr_off    = csr_addr - `CSR_PMPADDR0;
    is_misa     = (csr_addr == `CSR_MISA);
    is_mscratch = (csr_addr == `CSR_MSCRATCH);
    is_cfg      = (cfg_off < CFG_WORDS);
    is_addr     = (addr_off < `PMP_ENTRIES);
    cfg_sel     = cfg_off[CFG_IDX_W-1:0];
    addr_sel    = addr_off[`PMP_IDX_W-1:0];
  end

  assign op_ok      = (csr_op == CSR_RW) || (csr_op == CSR_RS) || (csr_op == CSR_RC);
  assign access_bad = !op_ok || !(is_misa || is_mscratch || is_cfg || is_addr);

  // Old value mux
  always_comb begin
    old_val = '0;
    if (is_misa)
      old_val = `MISA_VALUE;
    else if (is_mscratch)
      old_val = mscratch;
    else if (is_cfg)
      old_val = pmpcfg[cfg_sel].raw;
    else if (is_addr)
      old_val = pmpaddr[addr_sel];
  end

  // Read-modify-write result
  always_comb begin
    case (csr_op)
      CSR_RW:  new_val = csr_wdata;
      CSR_RS:  new_val = old_val | csr_wdata;
      CSR_RC:  new_val = old_val & ~csr_wdata;
      default: new_val = old_val;
    endcase
  end

  // Four-phase handshake and response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      csr_ack     <= 1'b0;
      csr_rdata   <= '0;
      csr_invalid <= 1'b0;
    end else if (start) begin
      csr_ack     <= 1'b1;
      csr_rdata   <= access_bad ? '0 : old_val;
      csr_invalid <= access_bad;
    end else if (!csr_req) begin
      csr_ack     <= 1'b0;
    end
  end

  // Register storage, misa writes fall through unused
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mscratch <= '0;
      for (int i = 0; i < CFG_WORDS; i++) begin
        pmpcfg[i] <= '0;
      end
      for (int i = 0; i < `PMP_ENTRIES; i++) begin
        pmpaddr[i] <= '0;
      end
    end else if (start && !access_bad) begin
      if (is_mscratch)
        mscratch <= new_val;
      if (is_cfg)
        pmpcfg[cfg_sel].raw <= new_val;
      if (is_addr)
        pmpaddr[addr_sel] <= new_val;
    end
  end

  // Byte view of the config words fans out per entry
  always_comb begin
    for (int i = 0; i < `PMP_ENTRIES; i++) begin
      entry_cfg[i]  = pmpcfg[i / 4].entry[i % 4];
      entry_addr[i] = pmpaddr[i];
    end
  end

  ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(csr_ack) |-> $past(csr_req)
  );

endmodule

`default_nettype wire

/* pmp_entry.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pmp_consts.svh"

module pmp_entry
  import pmp_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`PA_WIDTH-1:0] lookup_addr,
  input  pmp_cfg_t             cfg,
  input  logic [`XLEN-1:0]     addr,
  input  logic [`XLEN-1:0]     prev_addr,
  output logic                 match,
  output logic [2:0]           perm
);

  logic [`XLEN-1:0] word_addr;
  logic [`XLEN-1:0] napot_ignore;
  logic             hit;

  // pmpaddr holds bits 33:2 of the physical address
  assign word_addr = lookup_addr[`PA_WIDTH-1:2];

  // Low t+1 bits set, t being the trailing ones of addr
  assign napot_ignore = addr ^ (addr + 1'b1);

  always_comb begin
    case (cfg.mode)
      TOR:     hit = (word_addr >= prev_addr) && (word_addr < addr);
      NA4:     hit = (word_addr == addr);
      NAPOT:   hit = ((word_addr ^ addr) & ~napot_ignore) == '0;
      default: hit = 1'b0;
    endcase
  end

  // Stage 1 register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      match <= 1'b0;
      perm  <= '0;
    end else begin
      match <= hit;
      perm  <= {cfg.x, cfg.w, cfg.r};
    end
  end

  off_never_matches: assert property (
    @(posedge clk) disable iff (!rst_n)
    (cfg.mode == OFF) |=> !match
  );

endmodule

`default_nettype wire

/* pmp_match_select.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pmp_consts.svh"

module pmp_match_select (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lookup_valid,
  input  logic [`PMP_ENTRIES-1:0] entry_match,
  input  logic [2:0]            entry_perm [`PMP_ENTRIES],
  output logic                  result_valid,
  output logic                  result_match,
  output logic [`PMP_IDX_W-1:0] result_index,
  output logic [2:0]            result_perm
);

  logic                  valid_s1;
  logic                  any_hit;
  logic                  sel_hit;
  logic [`PMP_IDX_W-1:0] hit_idx;

  // Scan from the top so the lowest set index is left standing
  always_comb begin
    any_hit = 1'b0;
    hit_idx = '0;
    for (int i = `PMP_ENTRIES - 1; i >= 0; i--) begin
      if (entry_match[i]) begin
        any_hit = 1'b1;
        hit_idx = `PMP_IDX_W'(i);
      end
    end
  end

  // Stale entry outputs are ignored without a lookup in flight
  assign sel_hit = valid_s1 && any_hit;

  // Valid lines up with the stage 1 entry registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_s1 <= 1'b0;
    end else begin
      valid_s1 <= lookup_valid;
    end
  end

  // Stage 2 result register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
      result_match <= 1'b0;
      result_index <= '0;
      result_perm  <= '0;
    end else begin
      result_valid <= valid_s1;
      result_match <= sel_hit;
      result_index <= sel_hit ? hit_idx : '0;
      result_perm  <= sel_hit ? entry_perm[hit_idx] : '0;
    end
  end

  result_two_after_lookup: assert property (
    @(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(lookup_valid, 2)
  );

endmodule

`default_nettype wire

/* pmp_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pmp_consts.svh"

module pmp_unit
  import pmp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   csr_req,
  input  logic [`CSR_ADDR_W-1:0] csr_addr,
  input  csr_op_t                csr_op,
  input  logic [`XLEN-1:0]       csr_wdata,
  output logic                   csr_ack,
  output logic [`XLEN-1:0]       csr_rdata,
  output logic                   csr_invalid,
  input  logic                   lookup_valid,
  input  logic [`PA_WIDTH-1:0]   lookup_addr,
  output logic                   result_valid,
  output logic                   result_match,
  output logic [`PMP_IDX_W-1:0]  result_index,
  output logic [2:0]             result_perm
);

  pmp_cfg_t                entry_cfg [`PMP_ENTRIES];
  logic [`XLEN-1:0]        entry_addr [`PMP_ENTRIES];
  logic [`XLEN-1:0]        prev_bound [`PMP_ENTRIES];
  logic [`PMP_ENTRIES-1:0] entry_match;
  logic [2:0]              entry_perm [`PMP_ENTRIES];

  csr_regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_req     (csr_req),
    .csr_addr    (csr_addr),
    .csr_op      (csr_op),
    .csr_wdata   (csr_wdata),
    .csr_ack     (csr_ack),
    .csr_rdata   (csr_rdata),
    .csr_invalid (csr_invalid),
    .entry_cfg   (entry_cfg),
    .entry_addr  (entry_addr)
  );

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : g_entry
    // TOR lower bound comes from the entry below, zero for entry 0
    if (i == 0) begin : g_first
      assign prev_bound[i] = '0;
    end else begin : g_rest
      assign prev_bound[i] = entry_addr[i-1];
    end

    pmp_entry u_entry (
      .clk         (clk),
      .rst_n       (rst_n),
      .lookup_addr (lookup_addr),
      .cfg         (entry_cfg[i]),
      .addr        (entry_addr[i]),
      .prev_addr   (prev_bound[i]),
      .match       (entry_match[i]),
      .perm        (entry_perm[i])
    );
  end

  pmp_match_select u_select (
    .clk          (clk),
    .rst_n        (rst_n),
    .lookup_valid (lookup_valid),
    .entry_match  (entry_match),
    .entry_perm   (entry_perm),
    .result_valid (result_valid),
    .result_match (result_match),
    .result_index (result_index),
    .result_perm  (result_perm)
  );

endmodule

`default_nettype wire

/* tb_pmp_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "pmp_consts.svh"

module tb_pmp_unit
  import pmp_pkg::*;
();

  localparam int WAIT_LIMIT = 50;

  typedef enum {K_CSR, K_SCRATCH, K_LOOKUP} row_kind_t;

  // One stimulus row, the CSR number rides in addr
  typedef struct {
    string                 name;
    row_kind_t             kind;
    logic [1:0]            op;
    logic [`PA_WIDTH-1:0]  addr;
    logic [`XLEN-1:0]      data;
    logic [`XLEN-1:0]      exp_data;
    logic                  exp_flag;
    logic [`PMP_IDX_W-1:0] exp_index;
    logic [2:0]            exp_perm;
  } row_t;

  typedef struct {
    string                 name;
    int                    due;
    logic                  match;
    logic [`PMP_IDX_W-1:0] index;
    logic [2:0]            perm;
  } pending_t;

  logic                   clk;
  logic                   rst_n;
  logic                   csr_req;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  csr_op_t                csr_op;
  logic [`XLEN-1:0]       csr_wdata;
  logic                   csr_ack;
  logic [`XLEN-1:0]       csr_rdata;
  logic                   csr_invalid;
  logic                   lookup_valid;
  logic [`PA_WIDTH-1:0]   lookup_addr;
  logic                   result_valid;
  logic                   result_match;
  logic [`PMP_IDX_W-1:0]  result_index;
  logic [2:0]             result_perm;

  row_t             rows [$];
  pending_t         pending [$];
  int               cyc = 0;
  logic [`XLEN-1:0] scratch_model;

  pmp_unit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_csr(input string name, input logic [`XLEN-1:0] exp_rdata,
                           input logic exp_invalid);
    if (csr_rdata !== exp_rdata || csr_invalid !== exp_invalid) begin
      $display("FAIL %s: expected rdata %h invalid %b, actual rdata %h invalid %b",
               name, exp_rdata, exp_invalid, csr_rdata, csr_invalid);
      abort_run();
    end
  endtask

  task automatic check_lookup(input string name, input logic exp_match,
                              input logic [`PMP_IDX_W-1:0] exp_index, input logic [2:0] exp_perm);
    if (result_match !== exp_match || result_index !== exp_index || result_perm !== exp_perm) begin
      $display("FAIL %s: expected match %b index %0d perm %b, actual match %b index %0d perm %b",
               name, exp_match, exp_index, exp_perm, result_match, result_index, result_perm);
      abort_run();
    end
  endtask

  // Reference for the write, set and clear rules
  function automatic logic [`XLEN-1:0] scratch_next(input logic [`XLEN-1:0] old,
                                                    input logic [1:0] op,
                                                    input logic [`XLEN-1:0] d);
    case (csr_op_t'(op))
      CSR_RW:  return d;
      CSR_RS:  return old | d;
      CSR_RC:  return old & ~d;
      default: return old;
    endcase
  endfunction

  task automatic add_csr(input string name, input logic [1:0] op, input logic [11:0] num,
                         input logic [31:0] data, input logic [31:0] exp_rdata,
                         input logic exp_invalid);
    rows.push_back('{name, K_CSR, op, `PA_WIDTH'(num), data, exp_rdata, exp_invalid, '0, '0});
  endtask

  task automatic add_scratch(input string name, input logic [1:0] op);
    rows.push_back('{name, K_SCRATCH, op, `PA_WIDTH'(`CSR_MSCRATCH), '0, '0, 1'b0, '0, '0});
  endtask

  task automatic add_lookup(input string name, input logic [`PA_WIDTH-1:0] addr,
                            input logic match, input logic [2:0] index, input logic [2:0] perm);
    rows.push_back('{name, K_LOOKUP, 2'd0, addr, '0, '0, match, index, perm});
  endtask

  task automatic build_table();
    // CSR rows: name, op, CSR number, write data, expected old value, expected invalid
    add_csr("misa_read", CSR_RS, `CSR_MISA, 32'h0, `MISA_VALUE, 1'b0);
    add_csr("misa_write", CSR_RW, `CSR_MISA, 32'hFFFF_FFFF, `MISA_VALUE, 1'b0);
    add_csr("misa_after", CSR_RC, `CSR_MISA, 32'h0, `MISA_VALUE, 1'b0);
    add_csr("unknown_csr", CSR_RW, 12'h7C0, 32'h1234, 32'h0, 1'b1);
    add_csr("illegal_op", 2'd3, `CSR_PMPADDR0, 32'h55, 32'h0, 1'b1);
    add_scratch("scratch_rw", CSR_RW);
    add_scratch("scratch_rs", CSR_RS);
    add_scratch("scratch_rc", CSR_RC);
    add_scratch("scratch_bad_op", 2'd3);
    add_scratch("scratch_final", CSR_RS);
    // Entries 0..3 TOR r, TOR rw, NA4 x, NAPOT rwx
    add_csr("cfg0_write", CSR_RW, `CSR_PMPCFG0, 32'h1F14_0B09, 32'h0, 1'b0);
    // Entries 4..7 OFF, NAPOT w, NA4 r, TOR xr
    add_csr("cfg1_write", CSR_RW, `CSR_PMPCFG0 + 12'd1, 32'h0D11_1A07, 32'h0, 1'b0);
    add_csr("cfg0_read", CSR_RS, `CSR_PMPCFG0, 32'h0, 32'h1F14_0B09, 1'b0);
    add_csr("cfg1_read", CSR_RC, `CSR_PMPCFG0 + 12'd1, 32'h0, 32'h0D11_1A07, 1'b0);
    add_csr("addr0_first", CSR_RW, `CSR_PMPADDR0, 32'hDEAD_BEEF, 32'h0, 1'b0);
    add_csr("addr0_write", CSR_RW, `CSR_PMPADDR0, 32'h100, 32'hDEAD_BEEF, 1'b0);
    add_csr("addr1_write", CSR_RW, `CSR_PMPADDR0 + 12'd1, 32'h200, 32'h0, 1'b0);
    add_csr("addr2_write", CSR_RW, `CSR_PMPADDR0 + 12'd2, 32'h400, 32'h0, 1'b0);
    add_csr("addr3_write", CSR_RW, `CSR_PMPADDR0 + 12'd3, 32'h803, 32'h0, 1'b0);
    add_csr("addr4_write", CSR_RW, `CSR_PMPADDR0 + 12'd4, 32'h1000, 32'h0, 1'b0);
    add_csr("addr5_write", CSR_RW, `CSR_PMPADDR0 + 12'd5, 32'h1FF, 32'h0, 1'b0);
    add_csr("addr6_write", CSR_RW, `CSR_PMPADDR0 + 12'd6, 32'h1000, 32'h0, 1'b0);
    add_csr("addr7_write", CSR_RW, `CSR_PMPADDR0 + 12'd7, 32'h2000, 32'h0, 1'b0);
    add_csr("addr0_read", CSR_RS, `CSR_PMPADDR0, 32'h0, 32'h100, 1'b0);
    add_csr("addr1_read", CSR_RS, `CSR_PMPADDR0 + 12'd1, 32'h0, 32'h200, 1'b0);
    add_csr("addr2_read", CSR_RS, `CSR_PMPADDR0 + 12'd2, 32'h0, 32'h400, 1'b0);
    add_csr("addr3_read", CSR_RS, `CSR_PMPADDR0 + 12'd3, 32'h0, 32'h803, 1'b0);
    add_csr("addr4_read", CSR_RS, `CSR_PMPADDR0 + 12'd4, 32'h0, 32'h1000, 1'b0);
    add_csr("addr5_read", CSR_RS, `CSR_PMPADDR0 + 12'd5, 32'h0, 32'h1FF, 1'b0);
    add_csr("addr6_read", CSR_RS, `CSR_PMPADDR0 + 12'd6, 32'h0, 32'h1000, 1'b0);
    add_csr("addr7_read", CSR_RS, `CSR_PMPADDR0 + 12'd7, 32'h0, 32'h2000, 1'b0);
    // Lookups: name, byte address, expected match, index, perm as xwr
    add_lookup("tor0_low", 34'h0, 1'b1, 3'd0, 3'b001);
    add_lookup("tor0_top", 34'h3FF, 1'b1, 3'd0, 3'b001);
    add_lookup("tor0_bound", 34'h400, 1'b1, 3'd1, 3'b011);
    add_lookup("tor1_bound", 34'h800, 1'b1, 3'd5, 3'b010);
    add_lookup("napot5_top", 34'hFFC, 1'b1, 3'd5, 3'b010);
    add_lookup("na4_hit", 34'h1000, 1'b1, 3'd2, 3'b100);
    add_lookup("na4_next", 34'h1004, 1'b0, 3'd0, 3'b000);
    add_lookup("napot3_low", 34'h2000, 1'b1, 3'd3, 3'b111);
    add_lookup("napot3_high", 34'h201C, 1'b1, 3'd3, 3'b111);
    add_lookup("napot3_out", 34'h2020, 1'b0, 3'd0, 3'b000);
    add_lookup("off_then_na4", 34'h4000, 1'b1, 3'd6, 3'b001);
    add_lookup("tor7_mid", 34'h6000, 1'b1, 3'd7, 3'b101);
    add_lookup("tor7_bound", 34'h8000, 1'b0, 3'd0, 3'b000);
    add_lookup("top_of_space", 34'h3_FFFF_FFFC, 1'b0, 3'd0, 3'b000);
  endtask

  task automatic drain_lookups();
    int waited;
    waited = 0;
    while (pending.size() > 0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out waiting for outstanding lookup results");
        abort_run();
      end
    end
  endtask

  // Four-phase handshake, the old value is checked while ack is high
  task automatic csr_access(input row_t r, input logic [`XLEN-1:0] wdata,
                            input logic [`XLEN-1:0] exp_rdata, input logic exp_invalid);
    int waited;
    @(negedge clk);
    csr_req   = 1'b1;
    csr_addr  = r.addr[`CSR_ADDR_W-1:0];
    csr_op    = csr_op_t'(r.op);
    csr_wdata = wdata;
    waited    = 0;
    while (!csr_ack) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out waiting for csr_ack to rise in %s", r.name);
        abort_run();
      end
    end
    check_csr(r.name, exp_rdata, exp_invalid);
    csr_req = 1'b0;
    waited  = 0;
    while (csr_ack) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Timed out waiting for csr_ack to fall in %s", r.name);
        abort_run();
      end
    end
  endtask

  // Each lookup result is due exactly two cycles after its request
  always @(negedge clk) begin
    if (rst_n) begin
      if (pending.size() > 0 && pending[0].due == cyc) begin
        if (!result_valid) begin
          $display("Lookup %s produced no result in its cycle", pending[0].name);
          abort_run();
        end else begin
          check_lookup(pending[0].name, pending[0].match, pending[0].index, pending[0].perm);
          void'(pending.pop_front());
        end
      end else if (result_valid) begin
        $display("A lookup result appeared with no lookup due in this cycle");
        abort_run();
      end
    end
  end

  initial begin
    row_t             r;
    logic [`XLEN-1:0] wdata;
    logic             bad_op;
    void'($urandom(32'h0bbe_2320));
    rst_n         = 1'b0;
    csr_req       = 1'b0;
    csr_addr      = '0;
    csr_op        = CSR_RW;
    csr_wdata     = '0;
    lookup_valid  = 1'b0;
    lookup_addr   = '0;
    scratch_model = '0;
    build_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (rows[i]) begin
      r = rows[i];
      @(negedge clk);
      if (r.kind == K_LOOKUP) begin
        lookup_valid = 1'b1;
        lookup_addr  = r.addr;
        pending.push_back('{r.name, cyc + 2, r.exp_flag, r.exp_index, r.exp_perm});
      end else begin
        lookup_valid = 1'b0;
        drain_lookups();
        if (r.kind == K_SCRATCH) begin
          wdata  = $urandom;
          bad_op = (r.op == 2'd3);
          csr_access(r, wdata, bad_op ? '0 : scratch_model, bad_op);
          scratch_model = scratch_next(scratch_model, r.op, wdata);
        end else begin
          csr_access(r, r.data, r.exp_data, r.exp_flag);
        end
      end
    end
    @(negedge clk);
    lookup_valid = 1'b0;
    drain_lookups();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
pmp_pkg.sv
csr_regfile.sv
pmp_entry.sv
pmp_match_select.sv
pmp_unit.sv
tb_pmp_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_pmp_unit -o tb_pmp_unit

# tee keeps the pipeline status, the log decides the verdict
./obj_dir/tb_pmp_unit 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failures"
